//--- sim.f
+incdir+.
axis_pkg.sv
fifo_pkg.sv
sync_fifo.sv
mod_counter.sv
fifo2axis.sv
fifo_axis_top.sv
fifo_axis_assert.sv
tb_fifo_axis.sv

//--- Makefile
obj_dir/Vtb_fifo_axis: sim.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert --top-module tb_fifo_axis -f sim.f

.PHONY: run clean

run: obj_dir/Vtb_fifo_axis
	./obj_dir/Vtb_fifo_axis

clean:
	rm -rf obj_dir

//--- tb_fifo_axis.sv
`timescale 1ns/1ps
`include "axis_settings.svh"

module tb_fifo_axis
   import axis_pkg::*;
   import fifo_pkg::*;
;

   localparam int TIMEOUT = 1000;

   logic       clk_i;
   logic       rst_n_i;
   logic       wr_en_i;
   axis_data_t wr_data_i;
   logic       full_o;
   fifo_lvl_t  fifo_level_o;
   logic       en_i;
   axis_len_t  len_i;
   axis_lvl_t  level_o;
   logic       axis_tvalid_o;
   axis_data_t axis_tdata_o;
   logic       axis_tready_i;
   logic       axis_tlast_o;

   integer     seed;
   bit         ready_random;
   int         pkt_len;

   // words accepted by the FIFO, in write order
   axis_data_t wr_q[$];
   int         xfer_cnt;
   int         xfer_base;

   fifo_axis_top dut (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .wr_en_i      (wr_en_i),
      .wr_data_i    (wr_data_i),
      .full_o       (full_o),
      .fifo_level_o (fifo_level_o),
      .en_i         (en_i),
      .len_i        (len_i),
      .level_o      (level_o),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tready_i(axis_tready_i),
      .axis_tlast_o (axis_tlast_o)
   );

   always #20 clk_i = ~clk_i;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
         abort_run("value mismatch");
      end
   endtask

   // expected beat k: {tlast, data}
   function automatic logic [`AXIS_DATA_W:0] ref_beat(input int k, input int len);
      logic last;
      last = ((k % len) == (len - 1));
      return {last, wr_q[k]};
   endfunction

   // inputs change 2 ns after the edge
   task automatic next_cycle();
      int r;
      @(posedge clk_i);
      #2;
      if (ready_random) begin
         r = $random(seed);
         axis_tready_i = r[0];
      end
   endtask

   task automatic set_len(input int n);
      pkt_len = n;
      len_i = axis_len_t'(n);
   endtask

   task automatic apply_reset();
      rst_n_i = 1'b0;
      wr_en_i = 1'b0;
      repeat (5) next_cycle();
      wr_q.delete();
      xfer_base = xfer_cnt;
      rst_n_i = 1'b1;
      compare_value("axis_tvalid_o", 64'(axis_tvalid_o), 64'(0));
      compare_value("axis_tlast_o", 64'(axis_tlast_o), 64'(0));
      compare_value("full_o", 64'(full_o), 64'(0));
      compare_value("level_o", 64'(level_o), 64'(0));
      compare_value("fifo_level_o", 64'(fifo_level_o), 64'(0));
   endtask

   // with wait_room clear the write goes out even when full and is dropped
   task automatic push_word(input bit wait_room);
      int r;
      int waited;
      waited = 0;
      while (wait_room && full_o) begin
         wr_en_i = 1'b0;
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("FIFO stayed full while the producer waited for room");
         end
      end
      r = $random(seed);
      wr_en_i = 1'b1;
      wr_data_i = axis_data_t'(r);
      if (!full_o) begin
         wr_q.push_back(axis_data_t'(r));
      end
      next_cycle();
      wr_en_i = 1'b0;
   endtask

   task automatic write_words(input int n, input bit wait_room);
      repeat (n) push_word(wait_room);
   endtask

   task automatic wait_level(input axis_lvl_t target);
      int waited;
      waited = 0;
      while (level_o != target) begin
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("converter holding level never reached the expected value");
         end
      end
   endtask

   task automatic wait_full();
      int waited;
      waited = 0;
      while (!full_o) begin
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("FIFO never reported full under back-pressure");
         end
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((xfer_cnt - xfer_base) != wr_q.size()) begin
         next_cycle();
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("stream did not deliver all written words in time");
         end
      end
      compare_value("level_o", 64'(level_o), 64'(0));
   endtask

   // sampled mid-cycle, the transfer happens on the next rising edge
   always @(negedge clk_i) begin
      logic [`AXIS_DATA_W:0] exp_beat;
      int k;
      if (rst_n_i && axis_tvalid_o && axis_tready_i) begin
         k = xfer_cnt - xfer_base;
         if (k >= wr_q.size()) begin
            abort_run("stream transfer seen with no matching written word");
         end else begin
            exp_beat = ref_beat(k, pkt_len);
            compare_value("axis_tdata_o", 64'(axis_tdata_o),
                          64'(exp_beat[`AXIS_DATA_W-1:0]));
            compare_value("axis_tlast_o", 64'(axis_tlast_o),
                          64'(exp_beat[`AXIS_DATA_W]));
            xfer_cnt++;
         end
      end
   end

   initial begin
      axis_lvl_t held;
      int        base_cnt;
      clk_i = 1'b0;
      rst_n_i = 1'b0;
      wr_en_i = 1'b0;
      wr_data_i = '0;
      en_i = 1'b0;
      len_i = '0;
      axis_tready_i = 1'b0;
      seed = 72;
      ready_random = 1'b0;
      pkt_len = 1;
      xfer_cnt = 0;
      xfer_base = 0;

      // in-order stream, sink always ready
      set_len(4);
      apply_reset();
      en_i = 1'b1;
      axis_tready_i = 1'b1;
      write_words(40, 1'b1);
      wait_drain();

      // random back-pressure
      set_len(5);
      apply_reset();
      ready_random = 1'b1;
      write_words(60, 1'b1);
      wait_drain();
      ready_random = 1'b0;

      // stall: converter holds two, FIFO fills, extra writes dropped
      set_len(4);
      axis_tready_i = 1'b0;
      apply_reset();
      write_words(20, 1'b0);
      wait_level(2'd2);
      wait_full();
      compare_value("fifo_level_o", 64'(fifo_level_o), 64'(`FIFO_DEPTH));
      compare_value("level_o", 64'(level_o), 64'(2));
      compare_value("accepted words", 64'(wr_q.size()), 64'(`FIFO_DEPTH + 2));
      axis_tready_i = 1'b1;
      wait_drain();

      // enable gating, only held words may leave
      axis_tready_i = 1'b0;
      apply_reset();
      write_words(6, 1'b1);
      wait_level(2'd2);
      held = level_o;
      en_i = 1'b0;
      axis_tready_i = 1'b1;
      base_cnt = xfer_cnt;
      repeat (12) next_cycle();
      compare_value("transfers with en_i low", 64'(xfer_cnt - base_cnt), 64'(held));
      compare_value("level_o", 64'(level_o), 64'(0));
      en_i = 1'b1;
      wait_drain();

      // length change between packets
      set_len(1);
      apply_reset();
      write_words(6, 1'b1);
      wait_drain();
      set_len(3);
      apply_reset();
      write_words(9, 1'b1);
      wait_drain();

      $display("Regression passed");
      $finish;
   end

endmodule

//--- fifo_axis_assert.sv
`timescale 1ns/1ps
`include "axis_settings.svh"

module fifo_axis_assert
   import axis_pkg::*;
(
   input logic       clk_i,
   input logic       rst_n_i,
   input logic       fifo_empty_i,
   input logic       fifo_read_i,
   input axis_lvl_t  level_i,
   input logic       tvalid_i,
   input axis_data_t tdata_i,
   input logic       tready_i,
   input logic       tlast_i
);

   // stalled beat must hold still
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (tvalid_i && !tready_i) |=> (tvalid_i && $stable(tdata_i) && $stable(tlast_i)))
      else $error("stream beat changed while stalled");

   // two words held and a stalled sink leave no room for a third
   assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (level_i == 2'd2 && !tready_i) |-> !fifo_read_i)
      else $error("FIFO read issued with two words held and the sink stalled");

   // every word taken from the FIFO lands in the output stage
   assert property (@(posedge clk_i) disable iff (!rst_n_i) fifo_read_i |-> ##2 tvalid_i)
      else $error("word read from the FIFO never reached the output stage");

   // first edge out of reset
   assert property (@(posedge clk_i) $rose(rst_n_i) |-> !tvalid_i)
      else $error("tvalid high right after reset");

endmodule

bind fifo2axis fifo_axis_assert u_assert (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .fifo_empty_i(fifo_empty_i),
   .fifo_read_i (fifo_read_o),
   .level_i     (level_o),
   .tvalid_i    (axis_tvalid_o),
   .tdata_i     (axis_tdata_o),
   .tready_i    (axis_tready_i),
   .tlast_i     (axis_tlast_o)
);

//--- fifo_axis_top.sv
`timescale 1ns/1ps
`include "axis_settings.svh"

module fifo_axis_top
   import axis_pkg::*;
   import fifo_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   // producer side
   input  logic       wr_en_i,
   input  axis_data_t wr_data_i,
   output logic       full_o,
   output fifo_lvl_t  fifo_level_o,

   // converter control
   input  logic       en_i,
   input  axis_len_t  len_i,
   output axis_lvl_t  level_o,

   // AXI-Stream master
   output logic       axis_tvalid_o,
   output axis_data_t axis_tdata_o,
   input  logic       axis_tready_i,
   output logic       axis_tlast_o
);

   logic       fifo_read;
   logic       fifo_empty;
   axis_data_t fifo_rdata;

   sync_fifo u_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .wr_en_i  (wr_en_i),
      .wr_data_i(wr_data_i),
      .rd_en_i  (fifo_read),
      .rd_data_o(fifo_rdata),
      .empty_o  (fifo_empty),
      .full_o   (full_o),
      .level_o  (fifo_level_o)
   );

   fifo2axis u_f2a (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .en_i         (en_i),
      .len_i        (len_i),
      .level_o      (level_o),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_read),
      .fifo_rdata_i (fifo_rdata),
      .axis_tvalid_o(axis_tvalid_o),
      .axis_tdata_o (axis_tdata_o),
      .axis_tready_i(axis_tready_i),
      .axis_tlast_o (axis_tlast_o)
   );

endmodule

//--- fifo2axis.sv
`timescale 1ns/1ps
`include "axis_settings.svh"

module fifo2axis
   import axis_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       en_i,
   input  axis_len_t  len_i,
   output axis_lvl_t  level_o,

   // FIFO read side
   input  logic       fifo_empty_i,
   output logic       fifo_read_o,
   input  axis_data_t fifo_rdata_i,

   // AXI-Stream master
   output logic       axis_tvalid_o,
   output axis_data_t axis_tdata_o,
   input  logic       axis_tready_i,
   output logic       axis_tlast_o
);

   axis_len_t  word_cnt;
   axis_len_t  len_m1;
   logic       tlast_nxt;

   logic       read_ok;
   logic       fifo_read_r;
   logic       out_en;

   // skid stage
   logic       saved;
   axis_data_t saved_data;
   logic       saved_last;

   // output stage
   logic       out_valid;
   axis_data_t out_data;
   logic       out_last;

   // read when the sink takes a word, or when nothing is parked
   // and nothing is on its way back from the FIFO
   assign read_ok     = axis_tready_i | ~(saved | fifo_read_r);
   assign fifo_read_o = en_i & ~fifo_empty_i & read_ok;

   // output stage free when empty or draining this cycle
   assign out_en = ~out_valid | axis_tready_i;

   // packet boundary from the read count
   assign len_m1    = len_i - axis_len_t'(1);
   assign tlast_nxt = (word_cnt == len_m1);

   // count advances on the read, so it matches the word returned next cycle
   mod_counter u_word_cnt (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .en_i   (fifo_read_o),
      .mod_i  (len_m1),
      .count_o(word_cnt)
   );

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fifo_read_r <= 1'b0;
         saved       <= 1'b0;
         out_valid   <= 1'b0;
         out_last    <= 1'b0;
      end else begin
         fifo_read_r <= fifo_read_o;
         if (out_en) begin
            // the parked word goes first, otherwise the fresh one
            saved     <= 1'b0;
            out_valid <= saved | fifo_read_r;
            out_last  <= saved ? saved_last : (fifo_read_r & tlast_nxt);
         end else if (fifo_read_r) begin
            // output blocked, keep the word that just arrived
            saved <= 1'b1;
         end
      end
   end

   // skid data, captured on every returned word
   always_ff @(posedge clk_i) begin
      if (fifo_read_r) begin
         saved_data <= fifo_rdata_i;
         saved_last <= tlast_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_en) begin
         out_data <= saved ? saved_data : fifo_rdata_i;
      end
   end

   // words held: skid plus output
   always_comb begin
      if (saved && out_valid) begin
         level_o = 2'd2;
      end else if (saved || out_valid) begin
         level_o = 2'd1;
      end else begin
         level_o = 2'd0;
      end
   end

   assign axis_tvalid_o = out_valid;
   assign axis_tdata_o  = out_data;
   assign axis_tlast_o  = out_last;

endmodule

//--- mod_counter.sv
`timescale 1ns/1ps
`include "axis_settings.svh"

module mod_counter
   import axis_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  logic      en_i,
   input  axis_len_t mod_i,
   output axis_len_t count_o
);

   axis_len_t count_nxt;

   // wrap to zero once the limit has been reached
   assign count_nxt = (count_o == mod_i) ? '0 : count_o + axis_len_t'(1);

   // all ones at reset so the first enable lands on zero
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_o <= {`AXIS_LEN_W{1'b1}};
      end else if (en_i) begin
         count_o <= count_nxt;
      end
   end

endmodule

//--- sync_fifo.sv
`timescale 1ns/1ps
`include "axis_settings.svh"

module sync_fifo
   import axis_pkg::*;
   import fifo_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       wr_en_i,
   input  axis_data_t wr_data_i,
   input  logic       rd_en_i,
   output axis_data_t rd_data_o,
   output logic       empty_o,
   output logic       full_o,
   output fifo_lvl_t  level_o
);

   axis_data_t mem [`FIFO_DEPTH];

   fifo_addr_t wr_ptr;
   fifo_addr_t rd_ptr;
   fifo_lvl_t  level;

   logic       wr_ok;
   logic       rd_ok;

   // writes while full and reads while empty are dropped
   assign wr_ok = wr_en_i & ~full_o;
   assign rd_ok = rd_en_i & ~empty_o;

   // flags follow the occupancy counter
   assign empty_o = (level == '0);
   assign full_o  = (level == fifo_lvl_t'(`FIFO_DEPTH));
   assign level_o = level;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + fifo_addr_t'(1);
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + fifo_addr_t'(1);
         end
         // simultaneous push and pop leaves the count unchanged
         if (wr_ok && !rd_ok) begin
            level <= level + fifo_lvl_t'(1);
         end else if (rd_ok && !wr_ok) begin
            level <= level - fifo_lvl_t'(1);
         end
      end
   end

   // storage array
   always_ff @(posedge clk_i) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // read data shows up the cycle after the strobe
   always_ff @(posedge clk_i) begin
      if (rd_ok) begin
         rd_data_o <= mem[rd_ptr];
      end
   end

endmodule

//--- fifo_pkg.sv
`include "axis_settings.svh"

package fifo_pkg;

   // read and write pointers
   typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

   // occupancy, one bit wider to reach the full count
   typedef logic [`FIFO_ADDR_W:0] fifo_lvl_t;

endpackage

//--- axis_pkg.sv
`include "axis_settings.svh"

package axis_pkg;

   // one word on the stream and in the FIFO
   typedef logic [`AXIS_DATA_W-1:0] axis_data_t;

   // packet length and running word count
   typedef logic [`AXIS_LEN_W-1:0] axis_len_t;

   // words held inside the converter, 0 to 2
   typedef logic [1:0] axis_lvl_t;

endpackage

//--- axis_settings.svh
`ifndef AXIS_SETTINGS_SVH
`define AXIS_SETTINGS_SVH

// width of one stream word, also the FIFO word
`define AXIS_DATA_W 32

// packet length and word counter width
`define AXIS_LEN_W 8

// log2 of the FIFO depth
`define FIFO_ADDR_W 4

// number of FIFO entries
`define FIFO_DEPTH (1 << `FIFO_ADDR_W)

`endif
